// File: project.f
+incdir+verilog
verilog/pa_pkg.sv
verilog/alu_path.sv
verilog/addr_path.sv
verilog/bus_w.sv
verilog/pa_core.sv
verification/tb_clock.sv
verification/pa_core_assert.sv
verification/pa_core_tb.sv

// File: run.sh
#!/bin/sh
# build and run the P-A unit testbench with Verilator
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f project.f --top-module pa_core_tb \
	-o sim_pa > build.log 2>&1 &&
./obj_dir/sim_pa > sim.log 2>&1 ;
grep -q "TB PASSED" sim.log && echo "simulation passed" ||
{ echo "simulation failed, see build.log and sim.log"; exit 1; }

// File: verification/pa_core_assert.sv
/*
 * address path assertions
 * dad idle under ad_none, IC cleared the cycle after off
 */

`timescale 1ns/1ps

module pa_core_assert
	import pa_pkg::*;
(
	input logic  clk_sys,
	input logic  arst_n,
	input ctl_t  ctl,
	input logic  off,
	input word_t dad,
	input word_t ic
);

	property p_dad_idle;
		@(posedge clk_sys) disable iff (!arst_n)
			(ctl.ad_sel == ad_none) |-> (dad == '0);
	endproperty

	property p_off_clears_ic;
		@(posedge clk_sys) disable iff (!arst_n)
			off |=> (ic == '0);
	endproperty

	a_dad_idle: assert property (p_dad_idle)
		else $error("dad not zero while no address source is selected");

	a_off_clears_ic: assert property (p_off_clears_ic)
		else $error("IC not cleared after off");

endmodule

bind addr_path pa_core_assert u_pa_core_assert (
	.clk_sys (clk_sys),
	.arst_n  (arst_n),
	.ctl     (ctl),
	.off     (off),
	.dad     (dad),
	.ic      (ic)
);

// File: verification/pa_core_tb.sv
/*
 * P-A unit testbench
 * table of micro-operations checked against a register and ALU model
 */

`timescale 1ns/1ps

module pa_core_tb
	import pa_pkg::*;
();

	typedef struct packed {
		ctl_t  c;
		logic  stb;
		logic  off;
		logic  barnb;
		word_t ir;
		word_t l;
		word_t kl;
		word_t rdt;
		word_t ki;
	} row_t;

	logic   clk_sys;
	logic   arst_n;
	ctl_t   ctl;
	logic   ctl_stb;
	word_t  ir, l, kl, rdt, ki;
	logic   off, barnb;
	word_t  w, ddt, dad, ac, ar, ic;
	flags_t flags;
	logic   zga, wzi;

	row_t   rows[$];
	logic [15:0] lfsr_state;
	int     cycles = 0;
	int     limit;

	// model state and expected combinational values
	logic [15:0] m_ac, m_at, m_ar, m_ic;
	logic        m_wzi;
	logic [15:0] e_a, e_f, e_w, e_dad;
	flags_t      e_flags;
	logic        e_zga;

	tb_clock u_tb_clock (.clk_sys(clk_sys), .arst_n(arst_n));

	pa_core i_pa_core (
		.clk_sys (clk_sys), .arst_n (arst_n), .ctl (ctl), .ctl_stb (ctl_stb),
		.ir (ir), .l (l), .kl (kl), .rdt (rdt), .ki (ki), .off (off), .barnb (barnb),
		.w (w), .ddt (ddt), .dad (dad), .ac (ac), .ar (ar), .ic (ic),
		.flags (flags), .zga (zga), .wzi (wzi)
	);

	// taps 16,14,13,11
	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		logic fb;
		fb = s[15] ^ s[13] ^ s[12] ^ s[10];
		return {s[14:0], fb};
	endfunction

	// one LFSR step per bit taken
	function logic [15:0] rand_word();
		logic [15:0] v;
		v = '0;
		for (int i = 0; i < 16; i++) begin
			lfsr_state = lfsr_step(lfsr_state);
			v = {v[14:0], lfsr_state[0]};
		end
		return v;
	endfunction

	function row_t op_row(input ctl_t c, input logic stb);
		row_t r;
		r.c     = c;
		r.stb   = stb;
		r.off   = 1'b0;
		r.barnb = 1'b0;
		r.ir    = rand_word();
		r.l     = rand_word();
		r.kl    = rand_word();
		r.rdt   = rand_word();
		r.ki    = rand_word();
		return r;
	endfunction

	task automatic fail_now();
		$display("TB FAILED");
		$fatal(1, "stopping on first error");
	endtask

	task automatic check_word(input string name, input word_t got, input word_t exp);
		if (got !== exp) begin
			$display("Error at %0t: %s is %h, expected %h", $time, name, got, exp);
			fail_now();
		end
	endtask

	task automatic check_flags(input string name, input flags_t got, input flags_t exp);
		if (got !== exp) begin
			$display("Error at %0t: %s is %b, expected %b", $time, name, got, exp);
			fail_now();
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("Error at %0t: %s is %b, expected %b", $time, name, got, exp);
			fail_now();
		end
	endtask

	// ALU, W bus and address from the model registers
	task automatic compute_expected(input row_t r);
		logic [16:0] s;
		e_flags.carry = 1'b0;
		e_flags.ovf   = 1'b0;
		case (r.c.a_sel)
			a_ir:    e_a = r.ir;
			a_l:     e_a = r.l;
			a_ar:    e_a = m_ar;
			default: e_a = m_ic;
		endcase
		case (r.c.alu_op)
			op_add: begin
				s = {1'b0, m_ac} + {1'b0, e_a} + {16'h0000, r.c.carry_in};
				e_f = s[15:0];
				e_flags.carry = s[16];
				e_flags.ovf = (m_ac[15] == e_a[15]) && (e_f[15] != m_ac[15]);
			end
			op_sub: begin
				s = {1'b0, m_ac} - {1'b0, e_a} - {16'h0000, r.c.carry_in};
				e_f = s[15:0];
				e_flags.carry = ~s[16];
				e_flags.ovf = (m_ac[15] != e_a[15]) && (e_f[15] != m_ac[15]);
			end
			op_and:    e_f = m_ac & e_a;
			op_or:     e_f = m_ac | e_a;
			op_xor:    e_f = m_ac ^ e_a;
			op_pass_a: e_f = e_a;
			op_inc_a: begin
				e_f = e_a + 16'd1;
				e_flags.carry = (e_a == 16'hffff);
				e_flags.ovf = (e_a == 16'h7fff);
			end
			default: begin
				e_f = e_a - 16'd1;
				e_flags.carry = (e_a != 16'h0000);
				e_flags.ovf = (e_a == 16'h8000);
			end
		endcase
		e_flags.zero = (e_f == 16'h0000);
		e_flags.sign = e_f[15];
		case (r.c.w_sel)
			w_ir:    e_w = r.ir;
			w_kl:    e_w = {1'b0, r.kl[1:15]};
			w_rdt:   e_w = r.rdt;
			w_ki:    e_w = r.ki;
			w_at:    e_w = m_at;
			w_ac:    e_w = m_ac;
			w_a:     e_w = e_a;
			default: e_w = e_f;
		endcase
		case (r.c.ad_sel)
			ad_none: e_dad = 16'h0000;
			ad_ic:   e_dad = m_ic;
			ad_ar:   e_dad = m_ar;
			default: e_dad = (m_ic != 16'h0000) ? m_ic : m_ar;
		endcase
		e_zga = (r.kl == {~r.barnb, e_dad[14:0]});
	endtask

	// load beats increment and hold, and off comes first for IC
	task automatic update_model(input row_t r);
		if (r.off) begin
			m_ic = 16'h0000;
		end else if (r.stb && r.c.ld_ic) begin
			m_ic = e_w;
		end else if (r.stb && r.c.ic_inc) begin
			m_ic = m_ic + 16'd1;
		end
		if (r.stb) begin
			if (r.c.ld_ar) begin
				m_ar = e_w;
			end else if (r.c.ar_inc) begin
				m_ar = m_ar + 16'd1;
			end
			if (r.c.ld_at) begin
				m_at = e_f;
			end else if (r.c.at_shift) begin
				m_at = {r.c.carry_in, m_at[15:1]};
			end
			if (r.c.ld_ac) begin
				m_ac = e_w;
			end
			if (r.c.ld_wzi) begin
				m_wzi = e_flags.zero;
			end
		end
	endtask

	task automatic build_table();
		ctl_t c;
		row_t r;
		// idle after reset
		c = '0;
		rows.push_back(op_row(c, 1'b0));
		rows.push_back(op_row(c, 1'b0));
		// ALU functions on random AC and ir
		c = '0;
		c.w_sel = w_rdt;
		c.ld_ac = 1'b1;
		rows.push_back(op_row(c, 1'b1));
		for (int i = 0; i < 8; i++) begin
			c = '0;
			c.a_sel = a_ir;
			c.w_sel = w_f;
			c.alu_op = alu_op_e'(i);
			c.carry_in = i[0];
			rows.push_back(op_row(c, 1'b1));
		end
		// overflow and carry corners
		c = '0;
		c.w_sel = w_rdt;
		c.ld_ac = 1'b1;
		r = op_row(c, 1'b1);
		r.rdt = 16'h7fff;
		rows.push_back(r);
		c = '0;
		c.w_sel = w_f;
		c.alu_op = op_add;
		r = op_row(c, 1'b1);
		r.ir = 16'h0001;
		rows.push_back(r);
		r = op_row(c, 1'b1);
		r.ir = 16'h8001;
		rows.push_back(r);
		c.alu_op = op_sub;
		r = op_row(c, 1'b1);
		r.ir = 16'hffff;
		rows.push_back(r);
		c.carry_in = 1'b1;
		r = op_row(c, 1'b1);
		r.ir = 16'h0001;
		rows.push_back(r);
		c.alu_op = op_inc_a;
		r = op_row(c, 1'b1);
		r.ir = 16'hffff;
		rows.push_back(r);
		c.alu_op = op_dec_a;
		r = op_row(c, 1'b1);
		r.ir = 16'h8000;
		rows.push_back(r);
		// loads of AR, IC and AC from W
		c = '0;
		c.w_sel = w_ki;
		c.ld_ar = 1'b1;
		r = op_row(c, 1'b1);
		r.ki = 16'hffff;
		rows.push_back(r);
		c = '0;
		c.w_sel = w_ir;
		c.ld_ic = 1'b1;
		r = op_row(c, 1'b1);
		r.ir = 16'hffff;
		rows.push_back(r);
		c = '0;
		c.w_sel = w_kl;
		c.ld_ac = 1'b1;
		rows.push_back(op_row(c, 1'b1));
		// everything enabled but no strobe
		c = '1;
		c.w_sel = w_ki;
		c.ad_sel = ad_ar;
		rows.push_back(op_row(c, 1'b0));
		rows.push_back(op_row(c, 1'b0));
		// increments with wrap and the A bus from the address registers
		c = '0;
		c.ar_inc = 1'b1;
		c.ic_inc = 1'b1;
		c.a_sel = a_ar;
		c.w_sel = w_a;
		rows.push_back(op_row(c, 1'b1));
		c.a_sel = a_ic;
		rows.push_back(op_row(c, 1'b1));
		// load beats increment
		c = '0;
		c.w_sel = w_ki;
		c.ld_ar = 1'b1;
		c.ar_inc = 1'b1;
		c.ld_ic = 1'b1;
		c.ic_inc = 1'b1;
		r = op_row(c, 1'b1);
		r.ki = 16'h1234;
		rows.push_back(r);
		// off without and with a strobe
		c = '0;
		r = op_row(c, 1'b0);
		r.off = 1'b1;
		rows.push_back(r);
		c.w_sel = w_ir;
		c.ld_ic = 1'b1;
		rows.push_back(op_row(c, 1'b1));
		c.ic_inc = 1'b1;
		r = op_row(c, 1'b1);
		r.off = 1'b1;
		rows.push_back(r);
		// AT load, shifts, load over shift
		c = '0;
		c.a_sel = a_l;
		c.alu_op = op_pass_a;
		c.w_sel = w_at;
		c.ld_at = 1'b1;
		r = op_row(c, 1'b1);
		r.l = 16'h8001;
		rows.push_back(r);
		c.ld_at = 1'b0;
		c.at_shift = 1'b1;
		c.carry_in = 1'b1;
		rows.push_back(op_row(c, 1'b1));
		c.carry_in = 1'b0;
		rows.push_back(op_row(c, 1'b1));
		c.ld_at = 1'b1;
		rows.push_back(op_row(c, 1'b1));
		c = '0;
		c.w_sel = w_at;
		rows.push_back(op_row(c, 1'b1));
		// wzi only on a strobed ld_wzi
		c = '0;
		c.alu_op = op_pass_a;
		c.ld_wzi = 1'b1;
		r = op_row(c, 1'b1);
		r.ir = 16'h0000;
		rows.push_back(r);
		r = op_row(c, 1'b0);
		r.ir = 16'h0001;
		rows.push_back(r);
		rows.push_back(r);
		r.stb = 1'b1;
		rows.push_back(r);
		// address select and segment compare with IC zero then nonzero
		c = '0;
		r = op_row(c, 1'b1);
		r.off = 1'b1;
		rows.push_back(r);
		r = op_row(c, 1'b1);
		r.barnb = 1'b1;
		r.kl = 16'h0000;
		rows.push_back(r);
		r = op_row(c, 1'b1);
		r.kl = 16'h8000;
		rows.push_back(r);
		c.ad_sel = ad_ar;
		r = op_row(c, 1'b1);
		r.kl = 16'h9234;
		rows.push_back(r);
		r.barnb = 1'b1;
		r.kl = 16'h1234;
		rows.push_back(r);
		c.ad_sel = ad_ic_pri;
		r = op_row(c, 1'b1);
		r.kl = 16'h9234;
		rows.push_back(r);
		c.w_sel = w_ir;
		c.ld_ic = 1'b1;
		r = op_row(c, 1'b1);
		r.ir = 16'h0777;
		rows.push_back(r);
		c = '0;
		c.ad_sel = ad_ic_pri;
		r = op_row(c, 1'b1);
		r.kl = 16'h8777;
		rows.push_back(r);
		c.ad_sel = ad_ic;
		r = op_row(c, 1'b1);
		r.barnb = 1'b1;
		r.kl = 16'h0777;
		rows.push_back(r);
		rows.push_back(op_row(c, 1'b1));
	endtask

	task automatic apply_row(input row_t r);
		ctl     = r.c;
		ctl_stb = r.stb;
		off     = r.off;
		barnb   = r.barnb;
		ir      = r.ir;
		l       = r.l;
		kl      = r.kl;
		rdt     = r.rdt;
		ki      = r.ki;
	endtask

	// run limit
	always @(posedge clk_sys) begin
		cycles = cycles + 1;
		if (cycles > limit) begin
			$display("simulation ran past its cycle limit without finishing");
			$display("TB FAILED");
			$fatal(1, "timeout");
		end
	end

	initial begin
		ctl        = '0;
		ctl_stb    = 1'b0;
		off        = 1'b0;
		barnb      = 1'b0;
		ir         = '0;
		l          = '0;
		kl         = '0;
		rdt        = '0;
		ki         = '0;
		lfsr_state = 16'd53445;
		m_ac       = '0;
		m_at       = '0;
		m_ar       = '0;
		m_ic       = '0;
		m_wzi      = 1'b0;
		build_table();
		limit = rows.size() * 2 + 20;

		wait (arst_n === 1'b1);
		#5;
		check_word("ac", ac, 16'h0000);
		check_word("ar", ar, 16'h0000);
		check_word("ic", ic, 16'h0000);
		check_bit("wzi", wzi, 1'b0);
		check_word("ddt", ddt, 16'h0000);

		foreach (rows[i]) begin
			@(posedge clk_sys);
			#5;
			apply_row(rows[i]);
			#40;
			compute_expected(rows[i]);
			check_word("ac", ac, m_ac);
			check_word("ar", ar, m_ar);
			check_word("ic", ic, m_ic);
			check_bit("wzi", wzi, m_wzi);
			check_word("w", w, e_w);
			check_word("ddt", ddt, rows[i].stb ? e_w : 16'h0000);
			check_word("dad", dad, e_dad);
			check_flags("flags", flags, e_flags);
			check_bit("zga", zga, e_zga);
			update_model(rows[i]);
		end

		@(posedge clk_sys);
		#5;
		ctl_stb = 1'b0;
		off     = 1'b0;
		#40;
		check_word("ac", ac, m_ac);
		check_word("ar", ar, m_ar);
		check_word("ic", ic, m_ic);
		check_bit("wzi", wzi, m_wzi);
		$display("TB PASSED");
		$finish;
	end

endmodule

// File: verification/tb_clock.sv
/*
 * testbench clock and reset
 * 100 ns clk_sys, arst_n held low for the first two cycles
 */

`timescale 1ns/1ps

module tb_clock (
	output logic clk_sys,
	output logic arst_n
);

	initial begin
		clk_sys = 1'b0;
		forever #50 clk_sys = ~clk_sys;
	end

	initial begin
		arst_n = 1'b0;
		repeat (2) @(posedge clk_sys);
		#2 arst_n = 1'b1;
	end

endmodule

// File: verilog/addr_path.sv
/*
 * P-A address path
 * AR and IC registers, memory address select, segment compare
 */

`timescale 1ns/1ps

module addr_path
	import pa_pkg::*;
(
	input  logic  clk_sys,
	input  logic  arst_n,
	input  ctl_t  ctl,
	input  logic  ctl_stb,
	input  word_t w,
	input  word_t kl,
	input  logic  off,
	input  logic  barnb,
	output word_t ar,
	output word_t ic,
	output word_t dad,
	output logic  zga
);

	logic ic_nz;

	// address register where load beats increment
	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			ar <= '0;
		end else if (ctl_stb) begin
			if (ctl.ld_ar) begin
				ar <= w;
			end else if (ctl.ar_inc) begin
				ar <= ar + word_t'(1);
			end
		end
	end

	// instruction counter
	// off clears it even without a strobe
	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			ic <= '0;
		end else if (off) begin
			ic <= '0;
		end else if (ctl_stb) begin
			if (ctl.ld_ic) begin
				ic <= w;
			end else if (ctl.ic_inc) begin
				ic <= ic + word_t'(1);
			end
		end
	end

	assign ic_nz = (ic != '0);

	// memory address by priority select in place of a wired OR
	always_comb begin
		unique case (ctl.ad_sel)
			ad_none:   dad = '0;
			ad_ic:     dad = ic;
			ad_ar:     dad = ar;
			ad_ic_pri: dad = ic_nz ? ic : ar;
		endcase
	end

	// segment compare with bit 0 standing for the segment select
	assign zga = (kl == {~barnb, dad[1:word_w-1]});

endmodule

// File: verilog/alu_path.sv
/*
 * P-A arithmetic path
 * A bus select, ALU with flags, AC and AT registers, zero indicator wzi
 */

`timescale 1ns/1ps

module alu_path
	import pa_pkg::*;
(
	input  logic   clk_sys,
	input  logic   arst_n,
	input  ctl_t   ctl,
	input  logic   ctl_stb,
	input  word_t  ir,
	input  word_t  l,
	input  word_t  ar,
	input  word_t  ic,
	input  word_t  w,
	output word_t  a,
	output word_t  f,
	output word_t  ac,
	output word_t  at,
	output flags_t flags,
	output logic   wzi
);

	// adder operands and result with one extra bit for carry out
	word_t              add_x;
	word_t              add_y;
	logic               add_cin;
	logic               use_adder;
	logic [0:word_w]    sum;
	word_t              logic_res;

	// A bus
	always_comb begin
		unique case (ctl.a_sel)
			a_ir: a = ir;
			a_l:  a = l;
			a_ar: a = ar;
			a_ic: a = ic;
		endcase
	end

	// adder operand setup for the arithmetic functions
	always_comb begin
		add_x     = ac;
		add_y     = a;
		add_cin   = ctl.carry_in;
		use_adder = 1'b1;
		unique case (ctl.alu_op)
			op_add: begin
				add_x   = ac;
				add_y   = a;
				add_cin = ctl.carry_in;
			end
			op_sub: begin
				// ac + ~a + 1 - borrow
				add_x   = ac;
				add_y   = ~a;
				add_cin = ~ctl.carry_in;
			end
			op_inc_a: begin
				add_x   = a;
				add_y   = '0;
				add_cin = 1'b1;
			end
			op_dec_a: begin
				add_x   = a;
				add_y   = '1;
				add_cin = 1'b0;
			end
			default: begin
				use_adder = 1'b0;
			end
		endcase
	end

	assign sum = {1'b0, add_x} + {1'b0, add_y} + {{word_w{1'b0}}, add_cin};

	// bitwise functions and A pass-through
	always_comb begin
		unique case (ctl.alu_op)
			op_and:  logic_res = ac & a;
			op_or:   logic_res = ac | a;
			op_xor:  logic_res = ac ^ a;
			default: logic_res = a;
		endcase
	end

	assign f = use_adder ? sum[1:word_w] : logic_res;

	// flags with carry and overflow only from the adder
	always_comb begin
		flags.carry = use_adder & sum[0];
		flags.zero  = (f == '0);
		flags.sign  = f[0];
		flags.ovf   = use_adder & (add_x[0] == add_y[0]) & (f[0] != add_x[0]);
	end

	// accumulator loaded from W
	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			ac <= '0;
		end else if (ctl_stb && ctl.ld_ac) begin
			ac <= w;
		end
	end

	// AT takes the ALU result or shifts right
	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			at <= '0;
		end else if (ctl_stb) begin
			if (ctl.ld_at) begin
				at <= f;
			end else if (ctl.at_shift) begin
				at <= {ctl.carry_in, at[0:word_w-2]};
			end
		end
	end

	// registered zero indicator
	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			wzi <= 1'b0;
		end else if (ctl_stb && ctl.ld_wzi) begin
			wzi <= flags.zero;
		end
	end

endmodule

// File: verilog/bus_w.sv
/*
 * W bus combiner
 * routes one of the external words or a path result onto W
 */

`timescale 1ns/1ps

module bus_w
	import pa_pkg::*;
(
	input  w_sel_e w_sel,
	input  word_t  ir,
	input  word_t  kl,
	input  word_t  rdt,
	input  word_t  ki,
	input  word_t  at,
	input  word_t  ac,
	input  word_t  a,
	input  word_t  f,
	output word_t  w
);

	word_t kl_masked;

	// key switches with bit 0 masked off
	assign kl_masked = {1'b0, kl[1:word_w-1]};

	always_comb begin
		unique case (w_sel)
			// external words
			w_ir:  w = ir;
			w_kl:  w = kl_masked;
			w_rdt: w = rdt;
			w_ki:  w = ki;
			// arithmetic path results
			w_at:  w = at;
			w_ac:  w = ac;
			w_a:   w = a;
			w_f:   w = f;
		endcase
	end

endmodule

// File: verilog/pa_core.sv
/*
 * P-A unit top level
 * arithmetic path, address path and W bus combiner, one strobe per micro-op
 */

`timescale 1ns/1ps

module pa_core
	import pa_pkg::*;
(
	input  logic   clk_sys,
	input  logic   arst_n,
	input  ctl_t   ctl,
	input  logic   ctl_stb,
	input  word_t  ir,
	input  word_t  l,
	input  word_t  kl,
	input  word_t  rdt,
	input  word_t  ki,
	input  logic   off,
	input  logic   barnb,
	output word_t  w,
	output word_t  ddt,
	output word_t  dad,
	output word_t  ac,
	output word_t  ar,
	output word_t  ic,
	output flags_t flags,
	output logic   zga,
	output logic   wzi
);

	word_t a;
	word_t f;
	word_t at;

	// A bus, ALU, AC, AT, wzi
	alu_path u_alu_path (
		.clk_sys (clk_sys),
		.arst_n  (arst_n),
		.ctl     (ctl),
		.ctl_stb (ctl_stb),
		.ir      (ir),
		.l       (l),
		.ar      (ar),
		.ic      (ic),
		.w       (w),
		.a       (a),
		.f       (f),
		.ac      (ac),
		.at      (at),
		.flags   (flags),
		.wzi     (wzi)
	);

	// AR, IC, memory address
	addr_path u_addr_path (
		.clk_sys (clk_sys),
		.arst_n  (arst_n),
		.ctl     (ctl),
		.ctl_stb (ctl_stb),
		.w       (w),
		.kl      (kl),
		.off     (off),
		.barnb   (barnb),
		.ar      (ar),
		.ic      (ic),
		.dad     (dad),
		.zga     (zga)
	);

	bus_w u_bus_w (
		.w_sel (ctl.w_sel),
		.ir    (ir),
		.kl    (kl),
		.rdt   (rdt),
		.ki    (ki),
		.at    (at),
		.ac    (ac),
		.a     (a),
		.f     (f),
		.w     (w)
	);

	// data out only while a micro-op is strobed
	assign ddt = ctl_stb ? w : '0;

endmodule

// File: verilog/pa_pkg.sv
/*
 * P-A unit shared definitions
 * machine word, micro-operation word, select codes and ALU flags
 */

package pa_pkg;

	// machine word width with bit 0 as the most significant bit
	localparam int word_w = 16;

	typedef logic [0:word_w-1] word_t;

	// A bus source
	typedef enum logic [1:0] {
		a_ir,
		a_l,
		a_ar,
		a_ic
	} a_sel_e;

	// W bus source
	typedef enum logic [2:0] {
		w_ir,
		w_kl,
		w_rdt,
		w_ki,
		w_at,
		w_ac,
		w_a,
		w_f
	} w_sel_e;

	// ALU function on A and AC
	// add gives ac + a + carry_in
	// sub gives ac - a - carry_in and sets carry when nothing is borrowed
	// inc/dec work on A alone
	typedef enum logic [2:0] {
		op_add,
		op_sub,
		op_and,
		op_or,
		op_xor,
		op_pass_a,
		op_inc_a,
		op_dec_a
	} alu_op_e;

	// memory address source
	// ad_ic_pri takes IC when it is nonzero and AR otherwise
	typedef enum logic [1:0] {
		ad_none,
		ad_ic,
		ad_ar,
		ad_ic_pri
	} ad_sel_e;

	// one micro-operation of 19 bits
	typedef struct packed {
		a_sel_e  a_sel;
		w_sel_e  w_sel;
		alu_op_e alu_op;
		logic    carry_in;
		logic    ld_ac;
		logic    ld_at;
		logic    ld_ar;
		logic    ld_ic;
		logic    ld_wzi;
		logic    at_shift;   // shift AT right with carry_in into bit 0
		logic    ar_inc;
		logic    ic_inc;
		ad_sel_e ad_sel;
	} ctl_t;

	// ALU result flags
	typedef struct packed {
		logic carry;   // out of bit 0
		logic zero;
		logic sign;    // result bit 0
		logic ovf;     // signed overflow
	} flags_t;

endpackage
